// ==== project.f ====
display_pkg.sv
game_pkg.sv
video_driver.sv
round_controller.sv
scoreboard.sv
party_box.sv
tb_party_box.sv

// ==== Makefile ====
# Verilator flow for the reaction buzzer.

TOP := tb_party_box

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module party_box

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_party_box.sv ====
`timescale 1ns/1ns

module tb_party_box;
	import display_pkg::*;

	localparam int ticks        = 40;           // cycles per countdown step.
	localparam int round_cycles = 6 * ticks;     // win to re-armed.
	localparam int line_cycles  = 1600;
	localparam int frame_cycles = line_cycles * 525;
	localparam int max_random   = 60;
	localparam int gap_max      = 16;
	// three directed rounds plus random ones, two frames of video checks, one frame margin.
	localparam int cycle_limit  = (3 + max_random) * (round_cycles + line_cycles + gap_max)
		+ 3 * frame_cycles;

	logic        CLOCK_50;
	logic        rst_n;
	logic [3:0]  KEY;
	logic [35:0] GPIO_1;
	logic [6:0]  HEX0;
	logic [6:0]  HEX1;
	logic [6:0]  HEX2;
	logic [6:0]  HEX3;
	logic [6:0]  HEX4;
	logic [6:0]  HEX5;
	logic [9:0]  LEDR;
	logic [7:0]  VGA_R;
	logic [7:0]  VGA_G;
	logic [7:0]  VGA_B;
	logic        VGA_BLANK_N;
	logic        VGA_CLK;
	logic        VGA_HS;
	logic        VGA_SYNC_N;
	logic        VGA_VS;
	int          cycle_count = 0;
	int          wins_a = 0;    // model scores without the wrap.
	int          wins_b = 0;

	party_box #(.ticks_per_second(ticks)) dut0 (
		.CLOCK_50, .rst_n, .KEY, .GPIO_1,
		.HEX0, .HEX1, .HEX2, .HEX3, .HEX4, .HEX5, .LEDR,
		.VGA_R, .VGA_G, .VGA_B, .VGA_BLANK_N, .VGA_CLK, .VGA_HS, .VGA_SYNC_N, .VGA_VS
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #20 CLOCK_50 = ~CLOCK_50; // 40 ns period.
	end

	always @(posedge CLOCK_50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			fail_run("run did not finish within the cycle limit");
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected)
		else fail_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
	endtask

	// digit to segment pattern, built from the package codes.
	function automatic logic [6:0] digit_seg(input int d);
		case (d)
			0: return seg_zero;
			1: return seg_one;
			2: return seg_two;
			3: return seg_three;
			4: return seg_four;
			5: return seg_five;
			6: return seg_six;
			7: return seg_seven;
			8: return seg_eight;
			9: return seg_nine;
			default: return seg_dark;
		endcase
	endfunction

	// active-low buttons driven on one rising edge.
	task automatic set_buttons(input bit a_down, input bit b_down);
		@(posedge CLOCK_50);
		GPIO_1[0] <= ~a_down;
		KEY[2]    <= ~b_down;
	endtask

	task automatic wait_line_start();
		@(negedge CLOCK_50);
		while (VGA_BLANK_N) @(negedge CLOCK_50);
		while (!VGA_BLANK_N) @(negedge CLOCK_50); // first visible pixel.
	endtask

	task automatic sample_pixel(input string name, input logic [23:0] expected);
		@(negedge CLOCK_50);
		while (!VGA_BLANK_N) @(negedge CLOCK_50);
		expect_equal(name, 32'(expected), 32'({VGA_R, VGA_G, VGA_B}));
	endtask

	// ==========================================================================
	// one round. who is 0 for A, 1 for B, 2 for both at once.
	// ==========================================================================
	task automatic play_round(input int who, input bit aligned, input string name);
		bit         a_wins;
		logic [9:0] win_leds;
		int         win_cycle;
		int         step_cycle;
		int         digit;
		a_wins   = (who != 1);                  // tie goes to A.
		win_leds = a_wins ? 10'b11111_00000 : 10'b00000_11111;
		if (aligned) wait_line_start();         // keeps the fill on screen.
		set_buttons(who != 1, who != 0);
		repeat (2) @(posedge CLOCK_50);         // first sample, then sync stage.
		@(negedge CLOCK_50);
		expect_equal({name, " leds before win"}, 32'd0, 32'(LEDR));
		@(posedge CLOCK_50);                    // second edge after first sample.
		GPIO_1[0] <= 1'b1;
		KEY[2]    <= 1'b1;
		@(negedge CLOCK_50);
		expect_equal({name, " winner leds"}, 32'(win_leds), 32'(LEDR));
		win_cycle = cycle_count;
		if (a_wins) wins_a++;
		else wins_b++;
		@(negedge CLOCK_50);                    // segment registers one behind.
		expect_equal({name, " winner digit"}, 32'(digit_seg(a_wins ? 1 : 2)), 32'(HEX1));
		expect_equal({name, " countdown start"}, 32'(digit_seg(5)), 32'(HEX0));
		step_cycle = cycle_count;
		digit      = 5;
		if (aligned) sample_pixel({name, " winner colour"},
			a_wins ? colour_player_a : colour_player_b);
		while (LEDR != 10'd0) begin
			@(negedge CLOCK_50);
			expect_equal({name, " winner held"}, 32'(digit_seg(a_wins ? 1 : 2)), 32'(HEX1));
			if (LEDR != 10'd0) expect_equal({name, " leds held"}, 32'(win_leds), 32'(LEDR));
			if (HEX0 != digit_seg(digit)) begin
				expect_equal({name, " countdown digit"}, 32'(digit_seg(digit - 1)), 32'(HEX0));
				expect_equal({name, " step length"}, ticks, cycle_count - step_cycle);
				digit      = digit - 1;
				step_cycle = cycle_count;
			end
			// both players mash during the countdown.
			if (digit == 3 && cycle_count - step_cycle == 5) set_buttons(1'b1, 1'b1);
			if (digit == 3 && cycle_count - step_cycle == 15) set_buttons(1'b0, 1'b0);
		end
		expect_equal({name, " last digit"}, 32'd0, digit);
		expect_equal({name, " round length"}, round_cycles, cycle_count - win_cycle);
		@(negedge CLOCK_50);
		expect_equal({name, " winner cleared"}, 32'(seg_zero), 32'(HEX1));
		expect_equal({name, " score a"}, 32'(digit_seg(wins_a % 10)), 32'(HEX5));
		expect_equal({name, " score b"}, 32'(digit_seg(wins_b % 10)), 32'(HEX4));
		if (aligned) sample_pixel({name, " re-armed colour"}, colour_idle);
	endtask

	// ==========================================================================
	// VGA timing from the pins.
	// ==========================================================================
	task automatic measure_video();
		int fall_cycle;
		int rise_cycle;
		int visible;
		@(negedge CLOCK_50);
		while (!VGA_HS) @(negedge CLOCK_50);
		while (VGA_HS) @(negedge CLOCK_50);
		fall_cycle = cycle_count;
		while (!VGA_HS) @(negedge CLOCK_50);
		rise_cycle = cycle_count;
		while (VGA_HS) @(negedge CLOCK_50);
		expect_equal("hsync low time", 192, rise_cycle - fall_cycle);
		expect_equal("hsync period", line_cycles, cycle_count - fall_cycle);
		while (!VGA_VS) @(negedge CLOCK_50);
		while (VGA_VS) @(negedge CLOCK_50);      // up to a frame.
		fall_cycle = cycle_count;
		while (!VGA_VS) @(negedge CLOCK_50);
		expect_equal("vsync low time", 2 * line_cycles, cycle_count - fall_cycle);
		while (!VGA_BLANK_N) @(negedge CLOCK_50); // back porch, then first line.
		visible = 0;
		while (VGA_BLANK_N) begin
			visible++;
			@(negedge CLOCK_50);
		end
		expect_equal("visible pixels per line", 640, visible / 2); // two cycles a pixel.
	endtask

	// porch and sync stay black.
	blank_black: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		!VGA_BLANK_N |-> ({VGA_R, VGA_G, VGA_B} == 24'd0))
	else fail_run($sformatf("mismatch blanked rgb expected 0 actual %0h",
		$sampled({VGA_R, VGA_G, VGA_B})));

	one_led_half: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		(LEDR[9:5] == 5'd0) || (LEDR[4:0] == 5'd0))
	else fail_run("both halves of LEDR are lit at once");

	spare_dark: assert property (@(posedge CLOCK_50) (HEX2 == seg_dark) && (HEX3 == seg_dark))
	else fail_run("HEX2 or HEX3 is not dark");

	// pixel clock is CLOCK_50 halved.
	vga_clk_toggles: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		$past(rst_n) |-> (VGA_CLK != $past(VGA_CLK)))
	else fail_run("VGA_CLK did not toggle on a CLOCK_50 edge");

	sync_n_low: assert property (@(posedge CLOCK_50) !VGA_SYNC_N)
	else fail_run("VGA_SYNC_N is not held low");

	initial begin
		int pick;
		int gap;
		void'($urandom(32'he00dd7fb));
		rst_n  = 1'b0;
		KEY    = 4'hf;   // all keys up.
		GPIO_1 = '1;
		repeat (3) @(posedge CLOCK_50);
		rst_n <= 1'b1;
		@(negedge CLOCK_50);
		expect_equal("idle leds", 32'd0, 32'(LEDR));
		expect_equal("idle HEX0", 32'(seg_zero), 32'(HEX0));
		expect_equal("idle HEX1", 32'(seg_zero), 32'(HEX1));
		expect_equal("idle HEX4", 32'(seg_zero), 32'(HEX4));
		expect_equal("idle HEX5", 32'(seg_zero), 32'(HEX5));
		sample_pixel("idle colour", colour_idle);
		play_round(0, 1'b1, "a alone");
		play_round(1, 1'b1, "b alone");
		play_round(2, 1'b1, "tie");
		// random rounds until both scores have wrapped.
		for (int r = 0; r < max_random && (wins_a < 10 || wins_b < 10); r++) begin
			pick = $urandom % 5;
			gap  = $urandom % gap_max;
			repeat (gap) @(posedge CLOCK_50);
			play_round((pick < 2) ? 0 : ((pick < 4) ? 1 : 2), 1'b0,
				$sformatf("random round %0d", r));
		end
		assert (wins_a >= 10 && wins_b >= 10)
		else fail_run("random rounds ended before both scores wrapped past nine");
		measure_video();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== party_box.sv ====
`timescale 1ns/1ns

module party_box #(
	parameter int width            = 640,
	parameter int height           = 480,
	parameter int ticks_per_second = 50_000_000
) (
	input  logic        CLOCK_50,
	input  logic        rst_n,
	input  logic [3:0]  KEY,
	input  logic [35:0] GPIO_1,
	output logic [6:0]  HEX0,
	output logic [6:0]  HEX1,
	output logic [6:0]  HEX2,
	output logic [6:0]  HEX3,
	output logic [6:0]  HEX4,
	output logic [6:0]  HEX5,
	output logic [9:0]  LEDR,
	output logic [7:0]  VGA_R,
	output logic [7:0]  VGA_G,
	output logic [7:0]  VGA_B,
	output logic        VGA_BLANK_N,
	output logic        VGA_CLK,
	output logic        VGA_HS,
	output logic        VGA_SYNC_N,
	output logic        VGA_VS
);
	import display_pkg::*;
	import game_pkg::*;

	logic          win;
	player_e       winner;
	round_state_e  state;
	logic [2:0]    count_digit;
	pixel_colour_u colour; // whole screen is this colour.

	// ==========================================================================
	// game logic.
	// ==========================================================================
	round_controller #(.ticks_per_second(ticks_per_second)) ctrl0 (
		.CLOCK_50, .rst_n,
		.press_a_n(GPIO_1[0]), // player A button.
		.press_b_n(KEY[2]),    // player B button.
		.win, .winner, .state, .count_digit, .colour,
		.leds(LEDR)
	);

	scoreboard score0 (
		.CLOCK_50, .rst_n, .win, .winner, .state, .count_digit,
		.hex_count(HEX0), .hex_winner(HEX1),
		.hex_score_a(HEX5), .hex_score_b(HEX4)
	);

	assign HEX2 = seg_dark; // spare digits off.
	assign HEX3 = seg_dark;

	// ==========================================================================
	// video. every pixel gets the round colour.
	// ==========================================================================
	video_driver #(.width(width), .height(height)) video0 (
		.CLOCK_50, .rst_n,
		.red(colour.ch.red), .green(colour.ch.green), .blue(colour.ch.blue),
		.x(), .y(), // full-screen fill, coordinates not needed.
		.VGA_R, .VGA_G, .VGA_B, .VGA_BLANK_N,
		.VGA_CLK, .VGA_HS, .VGA_SYNC_N, .VGA_VS
	);

endmodule

// ==== scoreboard.sv ====
`timescale 1ns/1ns

module scoreboard (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,
	input  logic                   win,
	input  game_pkg::player_e      winner,
	input  game_pkg::round_state_e state,
	input  logic [2:0]             count_digit,
	output logic [6:0]             hex_count,
	output logic [6:0]             hex_winner,
	output logic [6:0]             hex_score_a,
	output logic [6:0]             hex_score_b
);
	import display_pkg::*;
	import game_pkg::*;

	logic [3:0] score_a; // decimal, 0..9.
	logic [3:0] score_b;

	// digit to active-low segments.
	function automatic logic [6:0] seg_code(input logic [3:0] value);
		logic [6:0] code;
		case (value)
			4'd0:    code = seg_zero;
			4'd1:    code = seg_one;
			4'd2:    code = seg_two;
			4'd3:    code = seg_three;
			4'd4:    code = seg_four;
			4'd5:    code = seg_five;
			4'd6:    code = seg_six;
			4'd7:    code = seg_seven;
			4'd8:    code = seg_eight;
			4'd9:    code = seg_nine;
			default: code = seg_dark; // not a digit.
		endcase
		return code;
	endfunction

	// next score, nine wraps to zero.
	function automatic logic [3:0] bump(input logic [3:0] score);
		return (score == 4'd9) ? 4'd0 : score + 4'd1;
	endfunction

	// ==========================================================================
	// win counters.
	// ==========================================================================
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			score_a <= '0;
			score_b <= '0;
		end else if (win) begin
			if (winner == player_a) begin
				score_a <= bump(score_a);
			end else begin
				score_b <= bump(score_b);
			end
		end
	end

	// ==========================================================================
	// segment registers. one cycle behind their inputs.
	// ==========================================================================
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			hex_count   <= seg_zero;
			hex_winner  <= seg_zero;
			hex_score_a <= seg_zero;
			hex_score_b <= seg_zero;
		end else begin
			hex_count   <= seg_code({1'b0, count_digit});
			hex_score_a <= seg_code(score_a);
			hex_score_b <= seg_code(score_b);
			if (state == countdown) begin
				hex_winner <= (winner == player_a) ? seg_one : seg_two; // player number.
			end else begin
				hex_winner <= seg_zero; // nobody yet.
			end
		end
	end

endmodule

// ==== round_controller.sv ====
`timescale 1ns/1ns

module round_controller #(
	parameter int ticks_per_second = 50_000_000
) (
	input  logic                       CLOCK_50,
	input  logic                       rst_n,
	input  logic                       press_a_n,
	input  logic                       press_b_n,
	output logic                       win,
	output game_pkg::player_e          winner,
	output game_pkg::round_state_e     state,
	output logic [2:0]                 count_digit,
	output display_pkg::pixel_colour_u colour,
	output logic [9:0]                 leds
);
	import game_pkg::*;
	import display_pkg::*;

	// tick counter sized to the rate.
	localparam int tick_w = (ticks_per_second > 1) ? $clog2(ticks_per_second) : 1;
	localparam logic [tick_w-1:0] tick_last = tick_w'(ticks_per_second - 1);

	localparam logic [9:0] leds_a = 10'b11111_00000; // left half.
	localparam logic [9:0] leds_b = 10'b00000_11111; // right half.

	logic [1:0]        sync_a;     // [1] is the safe copy.
	logic [1:0]        sync_b;
	logic              seen_a;
	logic              seen_b;
	logic [tick_w-1:0] tick_count;
	logic              tick_done;

	// ==========================================================================
	// button synchronizers. inverted so 1 means pressed.
	// ==========================================================================
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			sync_a <= '0;
			sync_b <= '0;
		end else begin
			sync_a <= {sync_a[0], ~press_a_n};
			sync_b <= {sync_b[0], ~press_b_n};
		end
	end

	assign seen_a    = sync_a[1];
	assign seen_b    = sync_b[1];
	assign tick_done = (tick_count == tick_last); // one second gone.

	// ==========================================================================
	// round FSM.
	// armed takes the first press, countdown runs 5..0 then re-arms.
	// ==========================================================================
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state       <= armed;
			win         <= 1'b0;
			winner      <= player_a;
			count_digit <= '0;
			tick_count  <= '0;
			colour      <= colour_idle;
			leds        <= '0;
		end else begin
			win <= 1'b0; // pulse by default.
			case (state)
				armed: begin
					if (seen_a || seen_b) begin
						win         <= 1'b1;
						state       <= countdown;
						count_digit <= count_start;
						tick_count  <= '0; // full second for the first step.
						if (seen_a) begin
							winner <= player_a; // A also takes a tie.
							colour <= colour_player_a;
							leds   <= leds_a;
						end else begin
							winner <= player_b;
							colour <= colour_player_b;
							leds   <= leds_b;
						end
					end
				end
				countdown: begin
					// presses ignored here.
					if (tick_done) begin
						tick_count <= '0;
						if (count_digit == 3'd0) begin
							state  <= armed; // zero held a full tick.
							colour <= colour_idle;
							leds   <= '0;
						end else begin
							count_digit <= count_digit - 3'd1;
						end
					end else begin
						tick_count <= tick_count + 1'b1;
					end
				end
				default: begin
					state <= armed;
				end
			endcase
		end
	end

endmodule

// ==== video_driver.sv ====
`timescale 1ns/1ns

module video_driver #(
	parameter int width  = 640,
	parameter int height = 480
) (
	input  logic       CLOCK_50,
	input  logic       rst_n,
	input  logic [7:0] red,
	input  logic [7:0] green,
	input  logic [7:0] blue,
	output logic [9:0] x,
	output logic [8:0] y,
	output logic [7:0] VGA_R,
	output logic [7:0] VGA_G,
	output logic [7:0] VGA_B,
	output logic       VGA_BLANK_N,
	output logic       VGA_CLK,
	output logic       VGA_HS,
	output logic       VGA_SYNC_N,
	output logic       VGA_VS
);

	// ==========================================================================
	// 640x480 at 60 Hz layout, in pixel clocks and lines.
	// ==========================================================================
	localparam int h_front = 16;
	localparam int h_sync  = 96;
	localparam int h_back  = 48;
	localparam int h_total = width + h_front + h_sync + h_back; // 800 at 640.

	localparam int v_front = 10;
	localparam int v_sync  = 2;
	localparam int v_back  = 33;
	localparam int v_total = height + v_front + v_sync + v_back; // 525 at 480.

	logic [9:0] h_count; // pixel within line.
	logic [9:0] v_count; // line within frame.
	logic       pix_en;
	logic       visible;
	logic       hs_next;
	logic       vs_next;

	// 25 MHz pixel clock, half of CLOCK_50.
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			VGA_CLK <= 1'b0;
		end else begin
			VGA_CLK <= ~VGA_CLK;
		end
	end

	assign pix_en = VGA_CLK; // one counter step per two CLOCK_50 cycles.

	// raster counters.
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			h_count <= '0;
			v_count <= '0;
		end else if (pix_en) begin
			if (h_count == 10'(h_total - 1)) begin
				h_count <= '0; // end of line.
				if (v_count == 10'(v_total - 1)) begin
					v_count <= '0; // end of frame.
				end else begin
					v_count <= v_count + 10'd1;
				end
			end else begin
				h_count <= h_count + 10'd1;
			end
		end
	end

	// decode counters.
	assign visible = (h_count < 10'(width)) && (v_count < 10'(height));
	assign hs_next = !((h_count >= 10'(width + h_front)) &&
		(h_count < 10'(width + h_front + h_sync))); // sync pulse low.
	assign vs_next = !((v_count >= 10'(height + v_front)) &&
		(v_count < 10'(height + v_front + v_sync)));

	// ==========================================================================
	// registered pins. sync, blank and colour move together.
	// ==========================================================================
	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			VGA_HS      <= 1'b1;
			VGA_VS      <= 1'b1;
			VGA_BLANK_N <= 1'b0;
			VGA_R       <= '0;
			VGA_G       <= '0;
			VGA_B       <= '0;
		end else begin
			VGA_HS      <= hs_next;
			VGA_VS      <= vs_next;
			VGA_BLANK_N <= visible;
			VGA_R       <= visible ? red : 8'd0;   // black in porch and sync.
			VGA_G       <= visible ? green : 8'd0;
			VGA_B       <= visible ? blue : 8'd0;
		end
	end

	assign x          = h_count;      // meaningful only while visible.
	assign y          = v_count[8:0];
	assign VGA_SYNC_N = 1'b0;         // no sync on green.

endmodule

// ==== game_pkg.sv ====
package game_pkg;

	// ==========================================================================
	// round state.
	// ==========================================================================
	typedef enum logic {
		armed     = 1'b0, // waiting for a press.
		countdown = 1'b1  // winner shown, HEX0 counting.
	} round_state_e;

	// ==========================================================================
	// players.
	// A is on GPIO_1[0], B on KEY[2].
	// ==========================================================================
	typedef enum logic {
		player_a = 1'b0,
		player_b = 1'b1
	} player_e;

	// countdown starts here on every win.
	parameter logic [2:0] count_start = 3'd5;

endpackage

// ==== display_pkg.sv ====
package display_pkg;

	// ==========================================================================
	// seven-segment codes.
	// active low, bit 6 is segment g, bit 0 is segment a.
	// ==========================================================================
	parameter logic [6:0] seg_zero  = 7'b1000000;
	parameter logic [6:0] seg_one   = 7'b1111001;
	parameter logic [6:0] seg_two   = 7'b0100100;
	parameter logic [6:0] seg_three = 7'b0110000;
	parameter logic [6:0] seg_four  = 7'b0011001;
	parameter logic [6:0] seg_five  = 7'b0010010;
	parameter logic [6:0] seg_six   = 7'b0000010;
	parameter logic [6:0] seg_seven = 7'b1111000;
	parameter logic [6:0] seg_eight = 7'b0000000;
	parameter logic [6:0] seg_nine  = 7'b0010000;

	parameter logic [6:0] seg_dark  = 7'b1111111; // all segments off.

	// ==========================================================================
	// pixel colour word.
	// one 24-bit value, or red/green/blue bytes.
	// ==========================================================================
	typedef union packed {
		logic [23:0] raw; // whole word, as the constants are written.
		struct packed {
			logic [7:0] red;   // top byte.
			logic [7:0] green;
			logic [7:0] blue;  // bottom byte.
		} ch;
	} pixel_colour_u;

	// fill colours.
	parameter pixel_colour_u colour_idle     = 24'hff_ff_ff; // white, armed.
	parameter pixel_colour_u colour_player_a = 24'hff_00_00; // red.
	parameter pixel_colour_u colour_player_b = 24'h00_00_ff; // blue.

endpackage
